// File: include/renamer_consts.svh
// Sizes must keep RN_PHYS_REGS above RN_ARCH_REGS; widths assume counts of two or more
`ifndef RENAMER_CONSTS_SVH
`define RENAMER_CONSTS_SVH

//////////////////////////////////////////////////
// Register counts
//////////////////////////////////////////////////

// Architectural registers visible to software
`define RN_ARCH_REGS 8
// Physical tags, arch set plus rename headroom
`define RN_PHYS_REGS 16
// Reorder buffer slots
`define RN_ROB_DEPTH 8
// Tags not mapped after reset
`define RN_FREE_DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS)

//////////////////////////////////////////////////
// Derived widths
//////////////////////////////////////////////////

`define RN_ARCH_W $clog2(`RN_ARCH_REGS)
`define RN_PHYS_W $clog2(`RN_PHYS_REGS)
`define RN_ROB_W  $clog2(`RN_ROB_DEPTH)

`endif

// File: hw/regmap_pkg.sv
// Register naming types only; rob_idx is a plain vector so this package stands alone
`include "renamer_consts.svh"

package regmap_pkg;

    //////////////////////////////////////////////////
    // Register tags
    //////////////////////////////////////////////////

    // Software-visible register number
    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;
    // Physical register tag
    typedef logic [`RN_PHYS_W-1:0] phys_reg_t;

    //////////////////////////////////////////////////
    // Dispatch payloads
    //////////////////////////////////////////////////

    // Request held stable for the whole req phase
    typedef struct packed {
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
        logic      has_dest;
    } rename_req_t;

    // Result latched on the fire edge
    typedef struct packed {
        phys_reg_t             src1_phys;
        logic                  src1_ready;
        phys_reg_t             src2_phys;
        logic                  src2_ready;
        phys_reg_t             new_phys;
        phys_reg_t             old_phys;
        logic [`RN_ROB_W-1:0]  rob_idx;
    } rename_resp_t;

endpackage

// File: hw/rob_pkg.sv
// Reorder buffer bookkeeping types; compile after regmap_pkg, whose tags these reuse
`include "renamer_consts.svh"

package rob_pkg;

    // Slot number inside the reorder buffer
    typedef logic [`RN_ROB_W-1:0] rob_idx_t;

    //////////////////////////////////////////////////
    // Stored slot
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic                  done;
        logic                  has_dest;
        regmap_pkg::arch_reg_t dest_arch;
        regmap_pkg::phys_reg_t new_phys;
        regmap_pkg::phys_reg_t old_phys;
    } rob_entry_t;

    //////////////////////////////////////////////////
    // Boundary packets
    //////////////////////////////////////////////////

    // One-cycle completion, no back-pressure
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } complete_t;

    // Registered retirement record
    typedef struct packed {
        logic                  valid;
        logic                  has_dest;
        regmap_pkg::arch_reg_t dest_arch;
        regmap_pkg::phys_reg_t new_phys;
        regmap_pkg::phys_reg_t old_phys;
    } commit_t;

endpackage

// File: hw/dispatch_ctrl.sv
// Four-phase dispatch; requester must hold rename_req_i stable until ack_o falls
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req_i,
    input  regmap_pkg::rename_req_t  rename_req_i,
    input  regmap_pkg::phys_reg_t    src1_phys_i,
    input  logic                     src1_ready_i,
    input  regmap_pkg::phys_reg_t    src2_phys_i,
    input  logic                     src2_ready_i,
    input  regmap_pkg::phys_reg_t    old_phys_i,
    input  regmap_pkg::phys_reg_t    free_tag_i,
    input  logic                     free_empty_i,
    input  rob_pkg::rob_idx_t        rob_tail_i,
    input  logic                     rob_full_i,
    output logic                     fire_o,
    output logic                     ack_o,
    output regmap_pkg::rename_resp_t rename_resp_o
);
    import regmap_pkg::*;

    logic         ack_q;
    logic         can_go;
    rename_resp_t resp_d;
    rename_resp_t resp_q;

    // Needs a slot, and a tag only if a dest is written
    assign can_go = !rob_full_i && (!free_empty_i || !rename_req_i.has_dest);
    // Single-cycle pulse, only while waiting for ack
    assign fire_o = req_i && !ack_q && can_go;

    // Assemble response from lookups
    always_comb begin
        resp_d.src1_phys  = src1_phys_i;
        resp_d.src1_ready = src1_ready_i;
        resp_d.src2_phys  = src2_phys_i;
        resp_d.src2_ready = src2_ready_i;
        resp_d.rob_idx    = rob_tail_i;
        // No dest means no tag traffic
        if (rename_req_i.has_dest) begin
            resp_d.new_phys = free_tag_i;
            resp_d.old_phys = old_phys_i;
        end else begin
            resp_d.new_phys = '0;
            resp_d.old_phys = '0;
        end
    end

    // Handshake state
    always_ff @(posedge clock) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else if (fire_o) begin
            ack_q <= 1'b1;
        end else if (ack_q && !req_i) begin
            // Release phase
            ack_q <= 1'b0;
        end
    end

    // Held for the whole ack phase
    always_ff @(posedge clock) begin
        if (fire_o) begin
            resp_q <= resp_d;
        end
    end

    assign ack_o         = ack_q;
    assign rename_resp_o = resp_q;

    // Payload stays put while the request is up
    a_req_held: assert property (
        @(posedge clock) disable iff (reset)
        req_i && $past(req_i) |-> $stable(rename_req_i)
    );

endmodule

// File: hw/map_table.sv
// Speculative map only; no recovery path, ready bits read as of the previous edge
`timescale 1ns/1ps
`include "renamer_consts.svh"

module map_table (
    input  logic                    clock,
    input  logic                    reset,
    input  regmap_pkg::rename_req_t rename_req_i,
    input  logic                    fire_i,
    input  regmap_pkg::phys_reg_t   new_phys_i,
    input  logic                    ready_set_valid_i,
    input  regmap_pkg::phys_reg_t   ready_set_phys_i,
    output regmap_pkg::phys_reg_t   src1_phys_o,
    output logic                    src1_ready_o,
    output regmap_pkg::phys_reg_t   src2_phys_o,
    output logic                    src2_ready_o,
    output regmap_pkg::phys_reg_t   old_phys_o
);
    import regmap_pkg::*;

    // Arch to phys mapping
    phys_reg_t                map_q [`RN_ARCH_REGS];
    // One bit per physical tag
    logic [`RN_PHYS_REGS-1:0] ready_q;
    logic                     remap;

    assign remap = fire_i && rename_req_i.has_dest;

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////

    // Sources see the map before this request's own remap
    assign src1_phys_o  = map_q[rename_req_i.src1];
    assign src2_phys_o  = map_q[rename_req_i.src2];
    assign src1_ready_o = ready_q[src1_phys_o];
    assign src2_ready_o = ready_q[src2_phys_o];
    // Tag freed when this dest retires
    assign old_phys_o   = map_q[rename_req_i.dest];

    //////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything committed
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
            ready_q <= '1;
        end else begin
            // Completion marks the value available
            if (ready_set_valid_i) begin
                ready_q[ready_set_phys_i] <= 1'b1;
            end
            // Fresh tag is pending until its completion
            if (remap) begin
                map_q[rename_req_i.dest] <= new_phys_i;
                ready_q[new_phys_i]      <= 1'b0;
            end
        end
    end

    // A tag completes once per allocation
    a_no_double_ready: assert property (
        @(posedge clock) disable iff (reset)
        ready_set_valid_i |-> !ready_q[ready_set_phys_i]
    );

endmodule

// File: hw/free_list.sv
// Holds at most RN_FREE_DEPTH tags; caller must gate pop on empty_o
`timescale 1ns/1ps
`include "renamer_consts.svh"

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pop_i,
    input  logic                  push_i,
    input  regmap_pkg::phys_reg_t push_tag_i,
    output regmap_pkg::phys_reg_t head_tag_o,
    output logic                  empty_o
);
    import regmap_pkg::*;

    localparam int PTR_W = $clog2(`RN_FREE_DEPTH);
    localparam int CNT_W = $clog2(`RN_FREE_DEPTH + 1);

    phys_reg_t        tags_q [`RN_FREE_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    assign head_tag_o = tags_q[head_q];
    assign empty_o    = (count_q == '0);

    //////////////////////////////////////////////////
    // Queue state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Upper tags free in ascending order
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                tags_q[i] <= phys_reg_t'(`RN_ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(`RN_FREE_DEPTH);
        end else begin
            // Pop advances the head
            if (pop_i) begin
                head_q <= (head_q == PTR_W'(`RN_FREE_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            // Retired tag goes to the tail
            if (push_i) begin
                tags_q[tail_q] <= push_tag_i;
                tail_q <= (tail_q == PTR_W'(`RN_FREE_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            // Both at once leave count alone
            case ({pop_i, push_i})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Dispatch must have tested empty
    a_no_pop_empty: assert property (
        @(posedge clock) disable iff (reset) pop_i |-> !empty_o
    );

    // Tag conservation across map, ROB and list
    a_no_push_full: assert property (
        @(posedge clock) disable iff (reset)
        push_i |-> (count_q < CNT_W'(`RN_FREE_DEPTH))
    );

endmodule

// File: hw/reorder_buffer.sv
// One retire per cycle; a completion must name a live entry that is not yet done
`timescale 1ns/1ps
`include "renamer_consts.svh"

module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc_i,
    input  rob_pkg::rob_entry_t   alloc_entry_i,
    input  rob_pkg::complete_t    complete_i,
    output rob_pkg::rob_idx_t     tail_o,
    output logic                  full_o,
    output logic                  ready_set_valid_o,
    output regmap_pkg::phys_reg_t ready_set_phys_o,
    output logic                  free_push_o,
    output regmap_pkg::phys_reg_t free_tag_o,
    output rob_pkg::commit_t      commit_o
);
    import rob_pkg::*;

    localparam int CNT_W = $clog2(`RN_ROB_DEPTH + 1);

    rob_entry_t       entries_q [`RN_ROB_DEPTH];
    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic [CNT_W-1:0] count_q;
    rob_entry_t       head_entry;
    rob_entry_t       done_entry;
    logic             retire;
    commit_t          commit_q;

    assign tail_o = tail_q;
    assign full_o = (count_q == CNT_W'(`RN_ROB_DEPTH));

    //////////////////////////////////////////////////
    // Completion side
    //////////////////////////////////////////////////

    // Entry named by this cycle's completion
    assign done_entry = entries_q[complete_i.rob_idx];

    // Wake the dest tag in the map, same cycle as the pulse
    assign ready_set_valid_o = complete_i.valid && done_entry.has_dest;
    assign ready_set_phys_o  = done_entry.new_phys;

    //////////////////////////////////////////////////
    // Retire side
    //////////////////////////////////////////////////

    assign head_entry = entries_q[head_q];
    // Done bit is registered, so retire lags completion
    assign retire     = head_entry.valid && head_entry.done;

    // Old mapping is dead once its overwriter retires
    assign free_push_o = retire && head_entry.has_dest;
    assign free_tag_o  = head_entry.old_phys;

    //////////////////////////////////////////////////
    // Slot state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
                entries_q[i].valid <= 1'b0;
                entries_q[i].done  <= 1'b0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // Append in program order
            if (alloc_i) begin
                entries_q[tail_q] <= alloc_entry_i;
                tail_q <= (tail_q == rob_idx_t'(`RN_ROB_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            // Out-of-order done marking
            if (complete_i.valid) begin
                entries_q[complete_i.rob_idx].done <= 1'b1;
            end
            // Pop the head
            if (retire) begin
                entries_q[head_q].valid <= 1'b0;
                entries_q[head_q].done  <= 1'b0;
                head_q <= (head_q == rob_idx_t'(`RN_ROB_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            case ({alloc_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Commit record, visible the cycle after retire
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_q.valid <= 1'b0;
        end else begin
            commit_q.valid <= retire;
            if (retire) begin
                commit_q.has_dest  <= head_entry.has_dest;
                commit_q.dest_arch <= head_entry.dest_arch;
                commit_q.new_phys  <= head_entry.new_phys;
                commit_q.old_phys  <= head_entry.old_phys;
            end
        end
    end

    assign commit_o = commit_q;

    // Completer may only name live, pending work
    a_complete_live: assert property (
        @(posedge clock) disable iff (reset)
        complete_i.valid |-> (done_entry.valid && !done_entry.done)
    );

endmodule

// File: hw/renamer_top.sv
// Rename and in-order retire core; completions arrive by ROB index, no flush support
`timescale 1ns/1ps

module renamer_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req_i,
    input  regmap_pkg::rename_req_t  rename_req_i,
    input  rob_pkg::complete_t       complete_i,
    output logic                     ack_o,
    output regmap_pkg::rename_resp_t rename_resp_o,
    output rob_pkg::commit_t         commit_o
);
    import regmap_pkg::*;
    import rob_pkg::*;

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    // Dispatch strobe
    logic       fire;
    logic       free_pop;
    // Map lookups
    phys_reg_t  src1_phys;
    logic       src1_ready;
    phys_reg_t  src2_phys;
    logic       src2_ready;
    phys_reg_t  old_phys;
    // Free list
    phys_reg_t  free_tag;
    logic       free_empty;
    // ROB status and feedback
    rob_idx_t   rob_tail;
    logic       rob_full;
    logic       ready_set_valid;
    phys_reg_t  ready_set_phys;
    logic       free_push;
    phys_reg_t  free_push_tag;
    rob_entry_t alloc_entry;

    // Tag consumed only by dest writers
    assign free_pop = fire && rename_req_i.has_dest;

    // New slot starts live and pending
    assign alloc_entry = '{valid: 1'b1, done: 1'b0, has_dest: rename_req_i.has_dest,
                           dest_arch: rename_req_i.dest, new_phys: free_tag,
                           old_phys: old_phys};

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    dispatch_ctrl dispatch_ctrl_0 (
        .clock(clock), .reset(reset), .req_i(req_i), .rename_req_i(rename_req_i),
        .src1_phys_i(src1_phys), .src1_ready_i(src1_ready),
        .src2_phys_i(src2_phys), .src2_ready_i(src2_ready),
        .old_phys_i(old_phys), .free_tag_i(free_tag), .free_empty_i(free_empty),
        .rob_tail_i(rob_tail), .rob_full_i(rob_full),
        .fire_o(fire), .ack_o(ack_o), .rename_resp_o(rename_resp_o)
    );

    map_table map_table_0 (
        .clock(clock), .reset(reset), .rename_req_i(rename_req_i), .fire_i(fire),
        .new_phys_i(free_tag), .ready_set_valid_i(ready_set_valid),
        .ready_set_phys_i(ready_set_phys),
        .src1_phys_o(src1_phys), .src1_ready_o(src1_ready),
        .src2_phys_o(src2_phys), .src2_ready_o(src2_ready), .old_phys_o(old_phys)
    );

    free_list free_list_0 (
        .clock(clock), .reset(reset), .pop_i(free_pop), .push_i(free_push),
        .push_tag_i(free_push_tag), .head_tag_o(free_tag), .empty_o(free_empty)
    );

    reorder_buffer reorder_buffer_0 (
        .clock(clock), .reset(reset), .alloc_i(fire), .alloc_entry_i(alloc_entry),
        .complete_i(complete_i), .tail_o(rob_tail), .full_o(rob_full),
        .ready_set_valid_o(ready_set_valid), .ready_set_phys_o(ready_set_phys),
        .free_push_o(free_push), .free_tag_o(free_push_tag), .commit_o(commit_o)
    );

endmodule

// File: verification/renamer_tb.sv
// Random dispatch and out-of-order completion against a model; fixed seed, 20-cycle budget each
`timescale 1ns/1ps
`include "renamer_consts.svh"

module renamer_tb;
    import regmap_pkg::*;
    import rob_pkg::*;

    localparam int N_DISPATCH     = 300;
    localparam int TIMEOUT_CYCLES = N_DISPATCH * 20;
    localparam int STALL_CYCLES   = 20;

    // One in-flight instruction as the model tracks it
    typedef struct packed {
        rob_idx_t  idx;
        logic      has_dest;
        arch_reg_t dest;
        phys_reg_t new_phys;
        phys_reg_t old_phys;
        logic      done;
        int        comp_cycle;
    } flight_t;

    logic         clock;
    logic         reset;
    logic         req;
    rename_req_t  rename_req;
    complete_t    complete;
    logic         ack;
    rename_resp_t rename_resp;
    commit_t      commit;

    ////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////

    phys_reg_t    map_m [`RN_ARCH_REGS];
    logic         ready_m [`RN_PHYS_REGS];
    phys_reg_t    free_q [$];
    flight_t      inflight [$];
    int           tail_m;
    // Bookkeeping
    int           cycle = 0;
    int           checks = 0;
    int           errors = 0;
    int           dispatched = 0;
    logic         ack_prev;
    logic         req_prev;
    rename_resp_t held_resp;
    // Ready-set carried by the pulse now on complete
    logic         comp_has;
    phys_reg_t    comp_tag;

    renamer_top dut_i (
        .clock(clock), .reset(reset), .req_i(req), .rename_req_i(rename_req),
        .complete_i(complete), .ack_o(ack), .rename_resp_o(rename_resp),
        .commit_o(commit)
    );

    always #2 clock = ~clock;

    // Run budget
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: only %0d dispatches after %0d cycles", dispatched, cycle);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at cycle %0d: %s", cycle, msg);
    endtask

    task automatic reset_model();
        // Identity map, all ready, upper tags free
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            map_m[i] = phys_reg_t'(i);
        end
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            ready_m[i] = 1'b1;
        end
        free_q.delete();
        for (int i = `RN_ARCH_REGS; i < `RN_PHYS_REGS; i++) begin
            free_q.push_back(phys_reg_t'(i));
        end
        inflight.delete();
        tail_m = 0;
    endtask

    ////////////////////////////////////////////////////
    // Response checks
    ////////////////////////////////////////////////////

    // Rename fired on the last edge; model state is still pre-edge
    task automatic check_dispatch(input int rob_pre);
        flight_t   ent;
        phys_reg_t s1;
        phys_reg_t s2;
        s1 = map_m[rename_req.src1];
        s2 = map_m[rename_req.src2];
        if (rob_pre >= `RN_ROB_DEPTH) begin
            flag_error("dispatch accepted while the reorder buffer was full");
        end
        check_eq("rename_resp_o.src1_phys", int'(rename_resp.src1_phys), int'(s1));
        check_eq("rename_resp_o.src1_ready", int'(rename_resp.src1_ready), int'(ready_m[s1]));
        check_eq("rename_resp_o.src2_phys", int'(rename_resp.src2_phys), int'(s2));
        check_eq("rename_resp_o.src2_ready", int'(rename_resp.src2_ready), int'(ready_m[s2]));
        check_eq("rename_resp_o.rob_idx", int'(rename_resp.rob_idx), tail_m);
        ent.idx        = rob_idx_t'(tail_m);
        ent.has_dest   = rename_req.has_dest;
        ent.dest       = rename_req.dest;
        ent.new_phys   = '0;
        ent.old_phys   = '0;
        ent.done       = 1'b0;
        ent.comp_cycle = 0;
        if (!rename_req.has_dest) begin
            check_eq("rename_resp_o.new_phys", int'(rename_resp.new_phys), 0);
            check_eq("rename_resp_o.old_phys", int'(rename_resp.old_phys), 0);
        end else if (free_q.size() == 0) begin
            flag_error("dispatch took a tag from an empty free list");
        end else begin
            // Oldest free tag, previous mapping of dest
            ent.new_phys = free_q.pop_front();
            ent.old_phys = map_m[rename_req.dest];
            check_eq("rename_resp_o.new_phys", int'(rename_resp.new_phys), int'(ent.new_phys));
            check_eq("rename_resp_o.old_phys", int'(rename_resp.old_phys), int'(ent.old_phys));
            map_m[rename_req.dest] = ent.new_phys;
            ready_m[ent.new_phys]  = 1'b0;
        end
        inflight.push_back(ent);
        tail_m = (tail_m + 1) % `RN_ROB_DEPTH;
        dispatched++;
    endtask

    // Retirement is strictly oldest first
    task automatic check_commit(input int rob_pre);
        flight_t head;
        if (rob_pre == 0) begin
            flag_error("commit_o fired with nothing in flight");
        end else begin
            head = inflight.pop_front();
            if (!head.done || (cycle - head.comp_cycle) < 2) begin
                flag_error("commit_o fired before its completion had taken effect");
            end
            check_eq("commit_o.has_dest", int'(commit.has_dest), int'(head.has_dest));
            if (head.has_dest) begin
                check_eq("commit_o.dest_arch", int'(commit.dest_arch), int'(head.dest));
                check_eq("commit_o.new_phys", int'(commit.new_phys), int'(head.new_phys));
                check_eq("commit_o.old_phys", int'(commit.old_phys), int'(head.old_phys));
                // Freed after any pop on the same edge
                free_q.push_back(head.old_phys);
            end
        end
    endtask

    ////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////

    // Random pending entry, at most one per cycle
    task automatic drive_completion(input bit allow);
        int      cand [$];
        int      k;
        flight_t ent;
        complete.valid   = 1'b0;
        complete.rob_idx = '0;
        comp_has         = 1'b0;
        if (allow && ($urandom % 2) == 1) begin
            for (int i = 0; i < inflight.size(); i++) begin
                if (!inflight[i].done) begin
                    cand.push_back(i);
                end
            end
            if (cand.size() > 0) begin
                k = cand[$urandom % cand.size()];
                ent = inflight[k];
                ent.done = 1'b1;
                ent.comp_cycle = cycle;
                inflight[k] = ent;
                complete.valid   = 1'b1;
                complete.rob_idx = ent.idx;
                comp_has = ent.has_dest;
                comp_tag = ent.new_phys;
            end
        end
    endtask

    // Four-phase requester with random gaps
    task automatic drive_request(input bit want, input bit force_dest);
        if (req && ack) begin
            req = 1'b0;
        end else if (!req && !ack && want && ($urandom % 4) != 0) begin
            rename_req.dest     = arch_reg_t'($urandom);
            rename_req.src1     = arch_reg_t'($urandom);
            rename_req.src2     = arch_reg_t'($urandom);
            rename_req.has_dest = force_dest || (($urandom % 4) != 0);
            req = 1'b1;
        end
    endtask

    // One cycle: check what the last edge did, update the model, drive
    task automatic step(input bit allow_comp, input bit want, input bit force_dest);
        logic ack_now;
        int   rob_pre;
        @(posedge clock);
        #0.5;
        ack_now = ack;
        rob_pre = inflight.size();
        if (ack_now && !ack_prev && !req_prev) begin
            flag_error("ack_o rose while req_i was low");
        end
        if (!ack_now && ack_prev && req_prev) begin
            flag_error("ack_o fell while req_i was still high");
        end
        if (ack_now && ack_prev) begin
            check_eq("rename_resp_o", int'(rename_resp), int'(held_resp));
        end
        if (ack_now && !ack_prev) begin
            held_resp = rename_resp;
            check_dispatch(rob_pre);
        end
        if (commit.valid) begin
            check_commit(rob_pre);
        end
        // Completion seen on this edge wakes its tag
        if (complete.valid && comp_has) begin
            ready_m[comp_tag] = 1'b1;
        end
        ack_prev = ack_now;
        drive_completion(allow_comp);
        drive_request(want, force_dest);
        // Level the next edge samples
        req_prev = req;
    endtask

    ////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////

    initial begin
        void'($urandom(99));
        clock      = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        rename_req = '0;
        complete   = '0;
        ack_prev   = 1'b0;
        req_prev   = 1'b0;
        held_resp  = '0;
        comp_has   = 1'b0;
        comp_tag   = '0;
        reset_model();
        repeat (10) @(posedge clock);
        #0.5;
        reset = 1'b0;
        check_eq("ack_o", int'(ack), 0);
        check_eq("commit_o.valid", int'(commit.valid), 0);

        // No completions, dest writers only; ROB and free list run dry together
        while (dispatched < `RN_ROB_DEPTH) begin
            step(1'b0, 1'b1, 1'b1);
        end
        repeat (STALL_CYCLES) step(1'b0, 1'b1, 1'b1);
        check_eq("dispatches before stall", dispatched, `RN_ROB_DEPTH);
        check_eq("ack_o during stall", int'(ack), 0);

        // Random mix, stalled request resumes after a retire
        while (dispatched < N_DISPATCH) begin
            step(1'b1, 1'b1, 1'b0);
        end

        // Drain everything, then watch for stray commits
        while (inflight.size() != 0 || ack_prev) begin
            step(1'b1, 1'b0, 1'b0);
        end
        repeat (5) step(1'b1, 1'b0, 1'b0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: renamer.f
+incdir+include
hw/regmap_pkg.sv
hw/rob_pkg.sv
hw/dispatch_ctrl.sv
hw/map_table.sv
hw/free_list.sv
hw/reorder_buffer.sv
hw/renamer_top.sv
verification/renamer_tb.sv

// File: Makefile
SIM      = verilator
TOP      = renamer_tb
FILELIST = renamer.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG      = sim.log
FAIL_MSG = Test FAILED
PASS_MSG = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
